// ==== dmr_pkg.sv ====
/*
  DMR lockstep subsystem shared definitions
  Data and bus widths, redundancy mode encoding and register map
*/

package dmr_pkg;

  localparam int unsigned DataWidth    = 32;
  localparam int unsigned AddrWidth    = 4;
  localparam int unsigned RegDataWidth = 32;
  localparam int unsigned McntWidth    = 8;

  // Core output word, also used for checkpoints
  typedef logic [DataWidth-1:0] data_t;

  // Configuration bus
  typedef logic [AddrWidth-1:0]    addr_t;
  typedef logic [RegDataWidth-1:0] reg_data_t;

  // Saturating mismatch count
  typedef logic [McntWidth-1:0] mcnt_t;

  // Per-core setback pulses, bit 0 is core A
  typedef logic [1:0] setback_t;

  // Redundancy mode of the core pair
  typedef enum logic [1:0] {
    MODE_NON_DMR     = 2'd0,
    MODE_DMR_RUN     = 2'd1,
    MODE_DMR_RESTORE = 2'd2
  } dmr_mode_e;

  // Register map
  // Bit 0 enables DMR
  localparam addr_t ADDR_ENABLE   = addr_t'(0);
  // Bit 0 rapid recovery, bit 1 force recovery (self-clearing)
  localparam addr_t ADDR_CONFIG   = addr_t'(1);
  // Mismatch count, any write clears it
  localparam addr_t ADDR_MISMATCH = addr_t'(2);
  // Current mode in bits 1:0
  localparam addr_t ADDR_STATUS   = addr_t'(3);

endpackage

// ==== dmr_regs.sv ====
/*
  DMR configuration registers
  Serves a four-phase req/ack bus, holds enable and recovery config,
  counts lockstep mismatches and reports the current mode
*/

module dmr_regs #(
  parameter bit RapidRecovery = 1'b1,
  parameter bit DefaultInDmr  = 1'b0
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               cfg_req_i,
  input  logic               cfg_we_i,
  input  dmr_pkg::addr_t     cfg_addr_i,
  input  dmr_pkg::reg_data_t cfg_wdata_i,
  output logic               cfg_ack_o,
  output dmr_pkg::reg_data_t cfg_rdata_o,
  input  dmr_pkg::dmr_mode_e mode_i,
  input  logic               mismatch_incr_i,
  input  logic               force_clr_i,
  output logic               dmr_enable_o,
  output logic               rapid_en_o,
  output logic               force_rec_o
);

  import dmr_pkg::*;

  logic      ack_q;
  logic      access;
  logic      enable_q;
  logic      rapid_q;
  logic      force_q;
  mcnt_t     mcnt_q;
  reg_data_t rdata_d;
  reg_data_t rdata_q;

  // One access per request, ack follows req by one cycle
  assign access = cfg_req_i & ~ack_q;

  always_comb begin
    rdata_d = '0;
    case (cfg_addr_i)
      ADDR_ENABLE:   rdata_d = reg_data_t'(enable_q);
      ADDR_CONFIG:   rdata_d = reg_data_t'({force_q, rapid_q});
      ADDR_MISMATCH: rdata_d = reg_data_t'(mcnt_q);
      ADDR_STATUS:   rdata_d = reg_data_t'(mode_i);
      default:       rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q    <= 1'b0;
      enable_q <= DefaultInDmr;
      rapid_q  <= 1'b0;
      force_q  <= 1'b0;
      mcnt_q   <= '0;
    end else begin
      ack_q <= cfg_req_i;
      if (access && cfg_we_i && cfg_addr_i == ADDR_ENABLE) begin
        enable_q <= cfg_wdata_i[0];
      end
      if (access && cfg_we_i && cfg_addr_i == ADDR_CONFIG) begin
        rapid_q <= cfg_wdata_i[0] & RapidRecovery;
        force_q <= cfg_wdata_i[1];
      end else if (force_clr_i) begin
        force_q <= 1'b0;
      end
      // Software clear wins over a coincident increment
      if (access && cfg_we_i && cfg_addr_i == ADDR_MISMATCH) begin
        mcnt_q <= '0;
      end else if (mismatch_incr_i && mcnt_q != '1) begin
        mcnt_q <= mcnt_q + mcnt_t'(1);
      end
    end
  end

  // Read data held for the whole ack phase
  always_ff @(posedge clk_i) begin
    if (access && !cfg_we_i) begin
      rdata_q <= rdata_d;
    end
  end

  assign cfg_ack_o    = ack_q;
  assign cfg_rdata_o  = rdata_q;
  assign dmr_enable_o = enable_q;
  assign rapid_en_o   = rapid_q;
  assign force_rec_o  = force_q;

endmodule

// ==== dmr_ctrl.sv ====
/*
  DMR redundancy mode controller
  Switches the core pair between independent, lockstep and restore,
  and raises synch and resynch requests towards software
*/

module dmr_ctrl #(
  parameter bit RapidRecovery = 1'b1,
  parameter bit DefaultInDmr  = 1'b0
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               dmr_enable_i,
  input  logic               rapid_en_i,
  input  logic               force_rec_i,
  input  logic               dmr_error_i,
  input  logic               recovery_done_i,
  input  logic               fetch_en_i,
  input  logic               cores_synch_i,
  output dmr_pkg::dmr_mode_e mode_o,
  output dmr_pkg::setback_t  setback_o,
  output logic               sw_synch_req_o,
  output logic               sw_resynch_req_o,
  output logic               grp_in_independent_o,
  output logic               compare_en_o,
  output logic               recovery_req_o,
  output logic               force_clr_o,
  output logic               mismatch_incr_o
);

  import dmr_pkg::*;

  localparam dmr_mode_e DefaultMode = DefaultInDmr ? MODE_DMR_RUN : MODE_NON_DMR;

  dmr_mode_e mode_d;
  dmr_mode_e mode_q;
  logic      rapid_active;
  logic      synch_req;
  logic      synch_req_q;
  logic      resynch_req;
  logic      resynch_req_q;

  assign rapid_active = RapidRecovery & rapid_en_i;

  always_comb begin
    mode_d      = mode_q;
    setback_o   = 2'b00;
    force_clr_o = 1'b0;
    synch_req   = 1'b0;
    resynch_req = 1'b0;

    case (mode_q)
      MODE_DMR_RUN: begin
        if (force_rec_i && rapid_active) begin
          force_clr_o = 1'b1;
          mode_d      = MODE_DMR_RESTORE;
        end
        // Without hardware recovery the mismatch goes to software
        if (dmr_error_i) begin
          if (rapid_active) begin
            mode_d = MODE_DMR_RESTORE;
          end else begin
            resynch_req = 1'b1;
          end
        end
      end
      MODE_DMR_RESTORE: begin
        if (recovery_done_i) begin
          mode_d = MODE_DMR_RUN;
        end
      end
      default: begin
        // Independent cores, wait for software to line them up
        if (dmr_enable_i) begin
          synch_req = 1'b1;
          if (cores_synch_i) begin
            mode_d    = MODE_DMR_RUN;
            setback_o = 2'b11;
          end
        end
      end
    endcase

    // Cores not fetching yet, so the mode can follow the enable bit
    if (!fetch_en_i) begin
      if (dmr_enable_i) begin
        synch_req = 1'b0;
        mode_d    = MODE_DMR_RUN;
      end else begin
        mode_d = MODE_NON_DMR;
      end
    end

    // Splitting is allowed at any time from lockstep
    if (mode_q == MODE_DMR_RUN && !dmr_enable_i) begin
      mode_d    = MODE_NON_DMR;
      setback_o = 2'b10;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mode_q        <= DefaultMode;
      synch_req_q   <= 1'b0;
      resynch_req_q <= 1'b0;
    end else begin
      mode_q        <= mode_d;
      synch_req_q   <= synch_req;
      resynch_req_q <= resynch_req;
    end
  end

  // Request pulses on the rising edge of each internal request
  assign sw_synch_req_o   = synch_req & ~synch_req_q;
  assign sw_resynch_req_o = resynch_req & ~resynch_req_q;

  assign mode_o               = mode_q;
  assign grp_in_independent_o = mode_q == MODE_NON_DMR;
  assign compare_en_o         = mode_q == MODE_DMR_RUN;
  assign recovery_req_o       = mode_q == MODE_DMR_RESTORE;
  assign mismatch_incr_o      = dmr_error_i;

endmodule

// ==== dmr_compare.sv ====
/*
  Lockstep output comparator
  Checks the paired core words and forwards the agreed one a cycle later
*/

module dmr_compare (
  input  logic           clk_i,
  input  logic           rst_ni,
  input  logic           compare_en_i,
  input  logic           core_a_valid_i,
  input  logic           core_b_valid_i,
  input  dmr_pkg::data_t core_a_data_i,
  input  dmr_pkg::data_t core_b_data_i,
  output logic           dmr_error_o,
  output logic           out_valid_o,
  output dmr_pkg::data_t out_data_o
);

  import dmr_pkg::*;

  logic  mismatch;
  logic  valid_d;
  logic  error_q;
  logic  valid_q;
  data_t data_q;

  // A lone valid counts as a mismatch as well
  assign mismatch = (core_a_valid_i != core_b_valid_i) ||
                    (core_a_valid_i && core_b_valid_i && core_a_data_i != core_b_data_i);

  // Outside lockstep core A passes unchecked
  assign valid_d = compare_en_i ? (core_a_valid_i & ~mismatch) : core_a_valid_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      error_q <= 1'b0;
      valid_q <= 1'b0;
    end else begin
      error_q <= compare_en_i & mismatch;
      valid_q <= valid_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (core_a_valid_i) begin
      data_q <= core_a_data_i;
    end
  end

  assign dmr_error_o = error_q;
  assign out_valid_o = valid_q;
  assign out_data_o  = data_q;

endmodule

// ==== dmr_recovery.sv ====
/*
  Rapid recovery unit
  Keeps the last agreed word as a checkpoint and replays it during restore
*/

module dmr_recovery #(
  parameter int RestoreCycles = 4
) (
  input  logic           clk_i,
  input  logic           rst_ni,
  input  logic           match_valid_i,
  input  dmr_pkg::data_t match_data_i,
  input  logic           recovery_req_i,
  output logic           recovery_done_o,
  output logic           restore_o,
  output dmr_pkg::data_t restore_data_o
);

  import dmr_pkg::*;

  localparam int CntWidth = (RestoreCycles > 1) ? $clog2(RestoreCycles) : 1;

  typedef logic [CntWidth-1:0] cnt_t;

  cnt_t  cnt_q;
  logic  last_cycle;
  data_t checkpoint_q;

  // Final cycle of the restore window
  assign last_cycle = recovery_req_i && (cnt_q == cnt_t'(RestoreCycles - 1));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (!recovery_req_i || last_cycle) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_q + cnt_t'(1);
    end
  end

  // Checkpoint frozen while a restore is running
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      checkpoint_q <= '0;
    end else if (match_valid_i && !recovery_req_i) begin
      checkpoint_q <= match_data_i;
    end
  end

  assign recovery_done_o = last_cycle;
  assign restore_o       = recovery_req_i;
  assign restore_data_o  = checkpoint_q;

endmodule

// ==== dmr_top.sv ====
/*
  DMR lockstep subsystem top level
  Registers, mode controller, comparator and rapid recovery unit
*/

module dmr_top #(
  parameter bit RapidRecovery = 1'b1,
  parameter int RestoreCycles = 4,
  parameter bit DefaultInDmr  = 1'b0
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               cfg_req_i,
  input  logic               cfg_we_i,
  input  dmr_pkg::addr_t     cfg_addr_i,
  input  dmr_pkg::reg_data_t cfg_wdata_i,
  output logic               cfg_ack_o,
  output dmr_pkg::reg_data_t cfg_rdata_o,
  input  logic               core_a_valid_i,
  input  dmr_pkg::data_t     core_a_data_i,
  input  logic               core_b_valid_i,
  input  dmr_pkg::data_t     core_b_data_i,
  input  logic               fetch_en_i,
  input  logic               cores_synch_i,
  output logic               out_valid_o,
  output dmr_pkg::data_t     out_data_o,
  output logic               restore_o,
  output dmr_pkg::data_t     restore_data_o,
  output dmr_pkg::setback_t  setback_o,
  output logic               sw_synch_req_o,
  output logic               sw_resynch_req_o,
  output logic               grp_in_independent_o
);

  import dmr_pkg::*;

  dmr_mode_e mode;
  logic      dmr_enable;
  logic      rapid_en;
  logic      force_rec;
  logic      force_clr;
  logic      mismatch_incr;
  logic      compare_en;
  logic      dmr_error;
  logic      recovery_req;
  logic      recovery_done;

  dmr_regs #(
    .RapidRecovery(RapidRecovery),
    .DefaultInDmr (DefaultInDmr)
  ) u_regs (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .cfg_req_i      (cfg_req_i),
    .cfg_we_i       (cfg_we_i),
    .cfg_addr_i     (cfg_addr_i),
    .cfg_wdata_i    (cfg_wdata_i),
    .cfg_ack_o      (cfg_ack_o),
    .cfg_rdata_o    (cfg_rdata_o),
    .mode_i         (mode),
    .mismatch_incr_i(mismatch_incr),
    .force_clr_i    (force_clr),
    .dmr_enable_o   (dmr_enable),
    .rapid_en_o     (rapid_en),
    .force_rec_o    (force_rec)
  );

  dmr_ctrl #(
    .RapidRecovery(RapidRecovery),
    .DefaultInDmr (DefaultInDmr)
  ) u_ctrl (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .dmr_enable_i        (dmr_enable),
    .rapid_en_i          (rapid_en),
    .force_rec_i         (force_rec),
    .dmr_error_i         (dmr_error),
    .recovery_done_i     (recovery_done),
    .fetch_en_i          (fetch_en_i),
    .cores_synch_i       (cores_synch_i),
    .mode_o              (mode),
    .setback_o           (setback_o),
    .sw_synch_req_o      (sw_synch_req_o),
    .sw_resynch_req_o    (sw_resynch_req_o),
    .grp_in_independent_o(grp_in_independent_o),
    .compare_en_o        (compare_en),
    .recovery_req_o      (recovery_req),
    .force_clr_o         (force_clr),
    .mismatch_incr_o     (mismatch_incr)
  );

  // Forwarded words double as checkpoint candidates
  dmr_compare u_compare (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .compare_en_i  (compare_en),
    .core_a_valid_i(core_a_valid_i),
    .core_b_valid_i(core_b_valid_i),
    .core_a_data_i (core_a_data_i),
    .core_b_data_i (core_b_data_i),
    .dmr_error_o   (dmr_error),
    .out_valid_o   (out_valid_o),
    .out_data_o    (out_data_o)
  );

  dmr_recovery #(
    .RestoreCycles(RestoreCycles)
  ) u_recovery (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .match_valid_i  (out_valid_o),
    .match_data_i   (out_data_o),
    .recovery_req_i (recovery_req),
    .recovery_done_o(recovery_done),
    .restore_o      (restore_o),
    .restore_data_o (restore_data_o)
  );

endmodule

// ==== tb_clk_gen.sv ====
/*
  Testbench clock and reset generator
  4 ns clock, active-low reset held for a fixed number of cycles
*/

module tb_clk_gen #(
  parameter int ResetCycles = 16
) (
  output logic clk_o,
  output logic rst_no
);

  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

// ==== tb_dmr_top.sv ====
/*
  DMR lockstep subsystem testbench
  Table-driven register, lockstep, resynch and recovery scenarios
*/

module tb_dmr_top;

  timeunit 1ns;
  timeprecision 100ps;

  import dmr_pkg::*;

  localparam int OP_RESET = 0;
  localparam int OP_REG_RW = 1;
  localparam int OP_RO_WRITE = 2;
  localparam int OP_ENABLE = 3;
  localparam int OP_WORDS = 4;
  localparam int OP_SPLIT = 5;
  localparam int OP_RESYNCH = 6;
  localparam int OP_RAPID = 7;
  localparam int OP_FORCE = 8;
  localparam int Timeout = 200;

  // One scenario step
  // Differ makes core B disagree with core A for all n words
  typedef struct packed {
    int        op;
    addr_t     addr;
    reg_data_t cfg;
    reg_data_t exp;
    int        n;
    logic      differ;
  } step_t;

  logic clk, rst_n;
  logic cfg_req, cfg_we, cfg_ack;
  addr_t cfg_addr;
  reg_data_t cfg_wdata, cfg_rdata;
  logic a_valid, b_valid, fetch_en, cores_synch;
  data_t a_data, b_data;
  logic out_valid, restore, sw_synch, sw_resynch, grp_indep;
  data_t out_data, restore_data;
  setback_t setback;

  step_t steps[14];
  data_t out_q[$];
  int synch_cnt, resynch_cnt, setback_cnt, restore_starts, restore_ends, restore_len;
  setback_t last_setback;
  data_t last_restore, last_agreed;
  logic restore_prev;

  tb_clk_gen #(.ResetCycles(16)) u_clk (.clk_o(clk), .rst_no(rst_n));

  dmr_top #(
    .RapidRecovery(1'b1),
    .RestoreCycles(4),
    .DefaultInDmr (1'b0)
  ) dut0 (
    .clk_i(clk), .rst_ni(rst_n),
    .cfg_req_i(cfg_req), .cfg_we_i(cfg_we), .cfg_addr_i(cfg_addr),
    .cfg_wdata_i(cfg_wdata), .cfg_ack_o(cfg_ack), .cfg_rdata_o(cfg_rdata),
    .core_a_valid_i(a_valid), .core_a_data_i(a_data),
    .core_b_valid_i(b_valid), .core_b_data_i(b_data),
    .fetch_en_i(fetch_en), .cores_synch_i(cores_synch),
    .out_valid_o(out_valid), .out_data_o(out_data),
    .restore_o(restore), .restore_data_o(restore_data),
    .setback_o(setback), .sw_synch_req_o(sw_synch),
    .sw_resynch_req_o(sw_resynch), .grp_in_independent_o(grp_indep)
  );

  // Monitors sample on the falling edge where all outputs are settled
  always @(negedge clk) begin
    if (rst_n) begin
      if (out_valid) out_q.push_back(out_data);
      if (sw_synch) synch_cnt++;
      if (sw_resynch) resynch_cnt++;
      if (setback != 2'b00) begin
        setback_cnt++;
        last_setback = setback;
      end
      if (restore && !restore_prev) begin
        restore_starts++;
        last_restore = restore_data;
        restore_len = 0;
      end
      if (restore) restore_len++;
      if (!restore && restore_prev) restore_ends++;
      restore_prev = restore;
    end
  end

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_data(input data_t got, input data_t exp, input string what);
    if (got !== exp)
      report_failure($sformatf("mismatch at %0t: %s got %h expected %h", $time, what, got, exp));
  endtask

  task automatic check_reg(input reg_data_t got, input reg_data_t exp, input string what);
    if (got !== exp)
      report_failure($sformatf("mismatch at %0t: %s got %h expected %h", $time, what, got, exp));
  endtask

  task automatic check_mode(input dmr_mode_e got, input dmr_mode_e exp, input string what);
    if (got !== exp)
      report_failure($sformatf("mismatch at %0t: %s got %s expected %s",
                               $time, what, got.name(), exp.name()));
  endtask

  task automatic check_setback(input setback_t got, input setback_t exp, input string what);
    if (got !== exp)
      report_failure($sformatf("mismatch at %0t: %s got %b expected %b", $time, what, got, exp));
  endtask

  function automatic int count_of(input int which);
    case (which)
      0: return synch_cnt;
      1: return setback_cnt;
      2: return resynch_cnt;
      3: return restore_starts;
      4: return restore_ends;
      default: return out_q.size();
    endcase
  endfunction

  task automatic wait_count(input int which, input int target, input string what);
    int t;
    t = 0;
    while (count_of(which) < target && t < Timeout) begin
      @(negedge clk);
      t++;
    end
    if (count_of(which) < target) report_failure({"timeout while waiting for ", what});
  endtask

  // Four-phase access that raises req, waits for ack, drops req and waits for ack low
  task automatic bus_access(input logic we, input addr_t addr, input reg_data_t wdata,
                            output reg_data_t rdata);
    int t;
    @(posedge clk);
    cfg_req <= 1'b1;
    cfg_we <= we;
    cfg_addr <= addr;
    cfg_wdata <= wdata;
    t = 0;
    do begin
      @(negedge clk);
      t++;
    end while (!cfg_ack && t < Timeout);
    if (!cfg_ack) report_failure("bus access never acknowledged");
    rdata = cfg_rdata;
    @(posedge clk);
    cfg_req <= 1'b0;
    t = 0;
    do begin
      @(negedge clk);
      t++;
    end while (cfg_ack && t < Timeout);
    if (cfg_ack) report_failure("bus ack never dropped after req went low");
  endtask

  task automatic reg_write(input addr_t addr, input reg_data_t wdata);
    reg_data_t unused;
    bus_access(1'b1, addr, wdata, unused);
  endtask

  task automatic reg_expect(input addr_t addr, input reg_data_t exp, input string what);
    reg_data_t rd;
    bus_access(1'b0, addr, '0, rd);
    check_reg(rd, exp, what);
  endtask

  task automatic mode_expect(input dmr_mode_e exp);
    reg_data_t rd;
    bus_access(1'b0, ADDR_STATUS, '0, rd);
    check_mode(dmr_mode_e'(rd[1:0]), exp, "status mode");
  endtask

  // Drives n words back to back and checks core A words come out in order
  task automatic drive_words(input int n, input logic differ, input logic expect_out);
    data_t exp_q[$];
    data_t w;
    out_q.delete();
    for (int i = 0; i < n; i++) begin
      w = $urandom;
      @(posedge clk);
      a_valid <= 1'b1;
      b_valid <= 1'b1;
      a_data <= w;
      b_data <= differ ? ~w : w;
      exp_q.push_back(w);
    end
    @(posedge clk);
    a_valid <= 1'b0;
    b_valid <= 1'b0;
    if (expect_out) begin
      // With one cycle of comparator latency only the last word is still in flight
      check_reg(out_q.size(), n - 1, "words forwarded one cycle after input");
      wait_count(5, n, "forwarded core words");
      for (int i = 0; i < n; i++) check_data(out_q[i], exp_q[i], "forwarded word");
      if (!differ) last_agreed = exp_q[n-1];
    end
  endtask

  task automatic enable_pair();
    int s0, b0;
    s0 = synch_cnt;
    b0 = setback_cnt;
    reg_write(ADDR_ENABLE, 32'd1);
    wait_count(0, s0 + 1, "synch request");
    repeat (4) @(negedge clk);
    check_reg(synch_cnt - s0, 1, "synch request pulses");
    @(posedge clk);
    cores_synch <= 1'b1;
    wait_count(1, b0 + 1, "setback on synch");
    @(posedge clk);
    cores_synch <= 1'b0;
    check_setback(last_setback, 2'b11, "setback on synch");
    mode_expect(MODE_DMR_RUN);
    check_reg(grp_indep, 0, "independent flag");
    reg_expect(ADDR_ENABLE, 32'd1, "enable readback");
  endtask

  task automatic recovery_expect(input int r0, input reg_data_t cnt, input string what);
    wait_count(3, r0 + 1, {what, " restore start"});
    wait_count(4, r0 + 1, {what, " restore end"});
    check_data(last_restore, last_agreed, {what, " restore data"});
    check_reg(restore_len, 4, {what, " restore length"});
    mode_expect(MODE_DMR_RUN);
    reg_expect(ADDR_MISMATCH, cnt, {what, " mismatch count"});
  endtask

  task automatic run_step(input step_t s);
    int r0;
    case (s.op)
      OP_RESET: begin
        mode_expect(MODE_NON_DMR);
        reg_expect(ADDR_ENABLE, 32'd0, "enable after reset");
        reg_expect(ADDR_MISMATCH, 32'd0, "count after reset");
      end
      OP_REG_RW, OP_RO_WRITE: begin
        reg_write(s.addr, s.cfg);
        reg_expect(s.addr, s.exp, "register readback");
      end
      OP_ENABLE: enable_pair();
      OP_WORDS: drive_words(s.n, s.differ, 1'b1);
      OP_SPLIT: begin
        r0 = setback_cnt;
        reg_write(ADDR_ENABLE, 32'd0);
        wait_count(1, r0 + 1, "setback on split");
        check_setback(last_setback, 2'b10, "setback on split");
        mode_expect(MODE_NON_DMR);
        check_reg(grp_indep, 1, "independent flag");
      end
      OP_RESYNCH: begin
        reg_write(ADDR_CONFIG, s.cfg);
        r0 = resynch_cnt;
        drive_words(1, 1'b1, 1'b0);
        wait_count(2, r0 + 1, "resynch request");
        repeat (4) @(negedge clk);
        check_reg(resynch_cnt - r0, 1, "resynch request pulses");
        check_reg(out_q.size(), 0, "words forwarded on mismatch");
        reg_expect(ADDR_MISMATCH, s.exp, "mismatch count");
        mode_expect(MODE_DMR_RUN);
      end
      OP_RAPID: begin
        reg_write(ADDR_CONFIG, s.cfg);
        r0 = restore_starts;
        drive_words(1, 1'b1, 1'b0);
        recovery_expect(r0, s.exp, "rapid");
      end
      default: begin
        r0 = restore_starts;
        reg_write(ADDR_CONFIG, s.cfg);
        recovery_expect(r0, s.exp, "forced");
        reg_expect(ADDR_CONFIG, 32'd1, "force bit cleared");
      end
    endcase
  endtask

  initial begin
    int t;
    cfg_req = 1'b0;
    cfg_we = 1'b0;
    cfg_addr = '0;
    cfg_wdata = '0;
    a_valid = 1'b0;
    b_valid = 1'b0;
    a_data = '0;
    b_data = '0;
    fetch_en = 1'b0;
    cores_synch = 1'b0;
    restore_prev = 1'b0;
    void'($urandom(82));
    steps = '{
      '{OP_RESET, ADDR_STATUS, 0, 0, 0, 0},
      '{OP_REG_RW, ADDR_CONFIG, 1, 1, 0, 0},
      '{OP_REG_RW, ADDR_CONFIG, 0, 0, 0, 0},
      '{OP_RO_WRITE, ADDR_STATUS, 3, 0, 0, 0},
      '{OP_ENABLE, ADDR_ENABLE, 1, 1, 0, 0},
      '{OP_WORDS, ADDR_STATUS, 0, 0, 8, 0},
      '{OP_SPLIT, ADDR_ENABLE, 0, 0, 0, 0},
      '{OP_WORDS, ADDR_STATUS, 0, 0, 6, 1},
      '{OP_ENABLE, ADDR_ENABLE, 1, 1, 0, 0},
      '{OP_RESYNCH, ADDR_CONFIG, 0, 1, 1, 1},
      '{OP_WORDS, ADDR_STATUS, 0, 0, 4, 0},
      '{OP_RAPID, ADDR_CONFIG, 1, 2, 1, 1},
      '{OP_WORDS, ADDR_STATUS, 0, 0, 3, 0},
      '{OP_FORCE, ADDR_CONFIG, 3, 2, 0, 0}
    };
    t = 0;
    while (!rst_n && t < Timeout) begin
      @(posedge clk);
      t++;
    end
    if (!rst_n) report_failure("reset never released");
    @(posedge clk);
    fetch_en <= 1'b1;
    foreach (steps[i]) run_step(steps[i]);
    repeat (4) @(posedge clk);
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

// ==== all.f ====
dmr_pkg.sv
dmr_regs.sv
dmr_ctrl.sv
dmr_compare.sv
dmr_recovery.sv
dmr_top.sv
tb_clk_gen.sv
tb_dmr_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the DMR testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --timescale 1ns/100ps -f all.f --top-module tb_dmr_top \
  --Mdir obj_dir -o sim_dmr && ./obj_dir/sim_dmr | tee sim.log
grep -qF '*** TEST PASSED ***' sim.log && echo "simulation passed" || {
  echo "simulation failed"
  exit 1
}
